//--- project.f
verilog/spu_cfg_pkg.sv
verilog/spu_op_pkg.sv
verilog/spu_operand_fanout.sv
verilog/spu_op_sll.sv
verilog/spu_result_pack.sv
verilog/spu_sll_vector.sv
verif/spu_sll_vector_chk.sv
verif/spu_sll_vector_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = spu_sll_vector_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/spu_sll_vector_tb.sv
module spu_sll_vector_tb;

    import spu_cfg_pkg::*;

    localparam int LATENCY      = 2;
    localparam int PERIOD       = 40;
    localparam int DRIVE_DELAY  = 2;   // input skew after the rising edge
    localparam int RESET_CYCLES = 8;
    localparam int STALL_CYCLES = 5;
    localparam int N_DIRECTED   = 10;  // commands issued by the directed tests
    localparam int N_RANDOM     = 50;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 + STALL_CYCLES
                                + (N_DIRECTED + N_RANDOM) * (LATENCY + 2);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                        clk;
    logic                        reset;
    logic                        cke;
    logic [LANES*LANE_BITS-1:0]  s_data;
    logic [LANES*SHIFT_BITS-1:0] s_shift_vec;
    logic [SHIFT_BITS-1:0]       s_shift_bcast;
    logic                        s_bcast;
    logic [LANES-1:0]            s_lane_en;
    logic                        s_valid;
    logic                        s_clear;
    logic [LANES*LANE_BITS-1:0]  m_data;
    logic [LANES-1:0]            m_overflow;

    logic [LANES*LANE_BITS-1:0]  exp_data;   // model copy of the held lane data
    logic [LANES-1:0]            exp_ovf;    // model copy of the held overflow
    int                          errors = 0;
    int                          checks = 0;
    int                          cycles = 0;
    integer                      seed   = 71966;

    spu_sll_vector #(
        .LANES      (LANES),
        .LANE_BITS  (LANE_BITS),
        .SHIFT_BITS (SHIFT_BITS),
        .LATENCY    (LATENCY),
        .CLEAR_DATA (CLEAR_VALUE)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .cke           (cke),
        .s_data        (s_data),
        .s_shift_vec   (s_shift_vec),
        .s_shift_bcast (s_shift_bcast),
        .s_bcast       (s_bcast),
        .s_lane_en     (s_lane_en),
        .s_valid       (s_valid),
        .s_clear       (s_clear),
        .m_data        (m_data),
        .m_overflow    (m_overflow)
    );

    // checker on the DUT outputs
    bind spu_sll_vector spu_sll_vector_chk #(
        .LANES     (LANES),
        .LANE_BITS (LANE_BITS)
    ) u_chk (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .m_data     (m_data),
        .m_overflow (m_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d  errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // reference model
    // --------------------

    // bit-by-bit shift returning {lost ones, shifted lane}
    function automatic logic [LANE_BITS:0] sll_model(input logic [LANE_BITS-1:0]  d,
                                                     input logic [SHIFT_BITS-1:0] sh);
        logic [LANE_BITS-1:0] r;
        logic                 lost;
        r    = '0;
        lost = 1'b0;
        for (int j = 0; j < LANE_BITS; j++) begin
            if (d[j]) begin
                if (j + int'(sh) < LANE_BITS) begin
                    r[j + int'(sh)] = 1'b1;
                end else begin
                    lost = 1'b1;   // bit left the lane
                end
            end
        end
        return {lost, r};
    endfunction

    task automatic update_model();
        logic [SHIFT_BITS-1:0] sh;
        logic [LANE_BITS:0]    out;
        for (int i = 0; i < LANES; i++) begin
            sh = s_bcast ? s_shift_bcast : s_shift_vec[i*SHIFT_BITS +: SHIFT_BITS];
            if (s_lane_en[i] && s_clear) begin   // clear wins
                exp_data[i*LANE_BITS +: LANE_BITS] = CLEAR_VALUE;
                exp_ovf[i]                         = 1'b0;
            end else if (s_lane_en[i] && s_valid) begin
                out = sll_model(s_data[i*LANE_BITS +: LANE_BITS], sh);
                exp_data[i*LANE_BITS +: LANE_BITS] = out[LANE_BITS-1:0];
                exp_ovf[i]                         = out[LANE_BITS];
            end
        end
    endtask

    // --------------------
    // helpers
    // --------------------

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_values(input string                      name,
                                input logic [LANES*LANE_BITS-1:0] want_data,
                                input logic [LANES-1:0]           want_ovf);
        checks++;
        assert (m_data === want_data) else begin
            errors++;
            $display("Fail %s: m_data expected %h actual %h", name, want_data, m_data);
        end
        checks++;
        assert (m_overflow === want_ovf) else begin
            errors++;
            $display("Fail %s: m_overflow expected %b actual %b", name, want_ovf, m_overflow);
        end
    endtask

    task automatic check_output(input string name);
        check_values(name, exp_data, exp_ovf);
    endtask

    // one strobe cycle, then wait out the pipeline
    task automatic apply_cmd(input string                       name,
                             input logic [LANES*LANE_BITS-1:0]  data,
                             input logic [LANES*SHIFT_BITS-1:0] shifts,
                             input logic [SHIFT_BITS-1:0]       bshift,
                             input logic                        bcast,
                             input logic [LANES-1:0]            en,
                             input logic                        valid,
                             input logic                        clear);
        s_data        = data;
        s_shift_vec   = shifts;
        s_shift_bcast = bshift;
        s_bcast       = bcast;
        s_lane_en     = en;
        s_valid       = valid;
        s_clear       = clear;
        update_model();
        next_cycle();
        s_valid = 1'b0;
        s_clear = 1'b0;
        repeat (LATENCY + 1) next_cycle();
        check_output(name);
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic test_reset();
        check_output("reset state");
    endtask

    task automatic test_per_lane_shifts();
        // lane 3 down to lane 0
        apply_cmd("per-lane a", 32'h810F_F001, {4'd1, 4'd3, 4'd8, 4'd0}, 4'd0, 1'b0,
                  4'b1111, 1'b1, 1'b0);
        apply_cmd("per-lane b", 32'h7F80_3CFF, {4'd7, 4'd4, 4'd9, 4'd2}, 4'd0, 1'b0,
                  4'b1111, 1'b1, 1'b0);
        apply_cmd("per-lane c", 32'h0001_0000, {4'd8, 4'd8, 4'd15, 4'd8}, 4'd0, 1'b0,
                  4'b1111, 1'b1, 1'b0);
    endtask

    task automatic test_bcast_priority();
        apply_cmd("broadcast", 32'hA5C3_1E80, {4'd0, 4'd1, 4'd2, 4'd3}, 4'd3, 1'b1,
                  4'b1111, 1'b1, 1'b0);
        apply_cmd("clear priority", 32'h1234_5678, {4'd1, 4'd1, 4'd1, 4'd1}, 4'd1, 1'b1,
                  4'b1111, 1'b1, 1'b1);
    endtask

    task automatic test_mask_hold();
        apply_cmd("mask load", 32'hC3A5_5A3C, {4'd1, 4'd2, 4'd3, 4'd4}, 4'd0, 1'b0,
                  4'b1111, 1'b1, 1'b0);
        apply_cmd("mask partial", 32'hFFFF_FFFF, {4'd4, 4'd4, 4'd4, 4'd4}, 4'd0, 1'b0,
                  4'b0101, 1'b1, 1'b0);
        apply_cmd("hold idle", 32'h0000_0000, {4'd0, 4'd0, 4'd0, 4'd0}, 4'd0, 1'b0,
                  4'b1111, 1'b0, 1'b0);
        apply_cmd("mask clear", 32'h0000_0000, {4'd0, 4'd0, 4'd0, 4'd0}, 4'd0, 1'b0,
                  4'b1000, 1'b0, 1'b1);
    endtask

    task automatic test_stall();
        logic [LANES*LANE_BITS-1:0] held_data;
        logic [LANES-1:0]           held_ovf;
        held_data     = exp_data;   // output before the new command lands
        held_ovf      = exp_ovf;
        s_data        = 32'hC366_1933;  // new data and overflow differ from held
        s_shift_bcast = 4'd2;
        s_bcast       = 1'b1;
        s_lane_en     = 4'b1111;
        s_valid       = 1'b1;
        update_model();
        next_cycle();               // command in the fanout register
        s_valid = 1'b0;
        next_cycle();               // command in the lane pipe
        cke = 1'b0;
        repeat (STALL_CYCLES) begin
            next_cycle();
            check_values("stall hold", held_data, held_ovf);
        end
        cke = 1'b1;
        repeat (LATENCY) next_cycle();
        check_output("stall release");
    endtask

    task automatic test_random();
        logic [31:0]                 rnd;
        logic [LANES*LANE_BITS-1:0]  data;
        logic [LANES*SHIFT_BITS-1:0] shifts;
        for (int n = 0; n < N_RANDOM; n++) begin
            for (int i = 0; i < LANES; i++) begin
                rnd = $random(seed);
                data[i*LANE_BITS +: LANE_BITS]    = rnd[LANE_BITS-1:0];
                shifts[i*SHIFT_BITS +: SHIFT_BITS] = rnd[LANE_BITS +: SHIFT_BITS];
            end
            rnd = $random(seed);
            // clear is rarer than valid
            apply_cmd("random", data, shifts, rnd[SHIFT_BITS-1:0], rnd[8],
                      rnd[12 +: LANES], rnd[16], rnd[17] & rnd[18]);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        reset         = 1'b1;
        cke           = 1'b1;
        s_data        = '0;
        s_shift_vec   = '0;
        s_shift_bcast = '0;
        s_bcast       = 1'b0;
        s_lane_en     = '0;
        s_valid       = 1'b0;
        s_clear       = 1'b0;
        exp_data      = {LANES{CLEAR_VALUE}};
        exp_ovf       = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        test_reset();
        test_per_lane_shifts();
        test_bcast_priority();
        test_mask_hold();
        test_stall();
        test_random();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verif/spu_sll_vector_chk.sv
module spu_sll_vector_chk #(
    parameter int LANES     = spu_cfg_pkg::LANES,
    parameter int LANE_BITS = spu_cfg_pkg::LANE_BITS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cke,
    input  logic [LANES*LANE_BITS-1:0] m_data,
    input  logic [LANES-1:0]           m_overflow
);

    // --------------------
    // reset
    // --------------------

    overflow_zero_after_reset: assert property (
        @(posedge clk) reset |=> (m_overflow == '0)
    ) else $error("m_overflow is not zero in the cycle after reset");

    // --------------------
    // stall
    // --------------------

    // an edge with cke low must not move the outputs
    data_stable_on_stall: assert property (
        @(posedge clk) (!reset && !cke) |=> $stable(m_data)
    ) else $error("m_data changed across a cycle with cke low");

    overflow_stable_on_stall: assert property (
        @(posedge clk) (!reset && !cke) |=> $stable(m_overflow)
    ) else $error("m_overflow changed across a cycle with cke low");

endmodule

//--- verilog/spu_sll_vector.sv
module spu_sll_vector #(
    parameter int LANES      = spu_cfg_pkg::LANES,
    parameter int LANE_BITS  = spu_cfg_pkg::LANE_BITS,
    parameter int SHIFT_BITS = spu_cfg_pkg::SHIFT_BITS,
    parameter int LATENCY    = 2,
    parameter logic [LANE_BITS-1:0] CLEAR_DATA = spu_cfg_pkg::CLEAR_VALUE
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cke,          // stalls every stage when low

    input  logic [LANES*LANE_BITS-1:0]    s_data,
    input  logic [LANES*SHIFT_BITS-1:0]   s_shift_vec,
    input  logic [SHIFT_BITS-1:0]         s_shift_bcast,
    input  logic                          s_bcast,
    input  logic [LANES-1:0]              s_lane_en,
    input  logic                          s_valid,
    input  logic                          s_clear,

    output logic [LANES*LANE_BITS-1:0]    m_data,
    output logic [LANES-1:0]              m_overflow
);

    import spu_op_pkg::*;

    lane_cmd_t [LANES-1:0] cmd;
    lane_res_t [LANES-1:0] res;

    spu_operand_fanout #(
        .LANES      (LANES),
        .LANE_BITS  (LANE_BITS),
        .SHIFT_BITS (SHIFT_BITS)
    ) u_fanout (
        .clk           (clk),
        .reset         (reset),
        .cke           (cke),
        .s_data        (s_data),
        .s_shift_vec   (s_shift_vec),
        .s_shift_bcast (s_shift_bcast),
        .s_bcast       (s_bcast),
        .s_lane_en     (s_lane_en),
        .s_valid       (s_valid),
        .s_clear       (s_clear),
        .cmd           (cmd)
    );

    // --------------------
    // lane array
    // --------------------

    generate
        for (genvar i = 0; i < LANES; i++) begin : g_lane
            spu_op_sll #(
                .LATENCY    (LATENCY),
                .LANE_BITS  (LANE_BITS),
                .SHIFT_BITS (SHIFT_BITS),
                .data_t     (logic [LANE_BITS-1:0]),
                .CLEAR_DATA (CLEAR_DATA)
            ) u_lane (
                .clk   (clk),
                .reset (reset),
                .cke   (cke),
                .cmd   (cmd[i]),
                .res   (res[i])
            );
        end
    endgenerate

    spu_result_pack #(
        .LANES      (LANES),
        .LANE_BITS  (LANE_BITS),
        .CLEAR_DATA (CLEAR_DATA)
    ) u_pack (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .res        (res),
        .m_data     (m_data),
        .m_overflow (m_overflow)
    );

endmodule

//--- verilog/spu_result_pack.sv
module spu_result_pack #(
    parameter int LANES     = spu_cfg_pkg::LANES,
    parameter int LANE_BITS = spu_cfg_pkg::LANE_BITS,
    parameter logic [LANE_BITS-1:0] CLEAR_DATA = spu_cfg_pkg::CLEAR_VALUE
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cke,

    input  spu_op_pkg::lane_res_t [LANES-1:0] res,

    output logic [LANES*LANE_BITS-1:0]        m_data,      // lane 0 in low bits
    output logic [LANES-1:0]                  m_overflow   // one flag per lane
);

    logic [LANES*LANE_BITS-1:0] data_next;
    logic [LANES-1:0]           ovf_next;

    // --------------------
    // gather lanes
    // --------------------

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            data_next[i*LANE_BITS +: LANE_BITS] = res[i].data;
            ovf_next[i]                         = res[i].overflow;
        end
    end

    // --------------------
    // output register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            m_data     <= {LANES{CLEAR_DATA}};  // every lane cleared
            m_overflow <= '0;
        end else if (cke) begin
            m_data     <= data_next;
            m_overflow <= ovf_next;
        end
    end

endmodule

//--- verilog/spu_op_sll.sv
module spu_op_sll #(
    parameter int  LATENCY    = 1,
    parameter int  LANE_BITS  = spu_cfg_pkg::LANE_BITS,
    parameter int  SHIFT_BITS = spu_cfg_pkg::SHIFT_BITS,
    parameter type data_t     = logic [LANE_BITS-1:0],
    parameter data_t CLEAR_DATA = data_t'(spu_cfg_pkg::CLEAR_VALUE)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cke,

    input  spu_op_pkg::lane_cmd_t cmd,
    output spu_op_pkg::lane_res_t res
);

    import spu_op_pkg::*;

    localparam int DW = $bits(data_t);  // payload width

    lane_cmd_t             issue;       // command at the last stage
    logic [SHIFT_BITS-1:0] amount;
    logic [DW-1:0]         src;
    logic [2*DW-1:0]       wide;        // upper half catches lost bits
    logic [DW-1:0]         shifted;
    logic                  spill;

    data_t                 hold_data;
    logic                  hold_ovf;

    // --------------------
    // command delay
    // --------------------

    generate
        if (LATENCY > 1) begin : g_pipe
            lane_cmd_t pipe [LATENCY-1];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < LATENCY-1; i++) begin
                        pipe[i] <= LANE_CMD_IDLE;
                    end
                end else if (cke) begin
                    pipe[0] <= cmd;
                    for (int i = 1; i < LATENCY-1; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            assign issue = pipe[LATENCY-2];
        end else begin : g_direct
            assign issue = cmd;  // hold register is the only stage
        end
    endgenerate

    // --------------------
    // shift and overflow
    // --------------------

    always_comb begin
        amount  = issue.shift;
        src     = DW'(issue.data);
        wide    = {{DW{1'b0}}, src} << amount;
        shifted = wide[DW-1:0];
        spill   = |wide[2*DW-1:DW];

        // full-width shift or more empties the lane
        if (int'(amount) >= DW) begin
            shifted = '0;
            spill   = |src;
        end
    end

    // --------------------
    // hold register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_data <= CLEAR_DATA;
            hold_ovf  <= 1'b0;
        end else if (cke) begin
            if (issue.clear) begin  // clear wins over valid
                hold_data <= CLEAR_DATA;
                hold_ovf  <= 1'b0;
            end else if (issue.valid) begin
                hold_data <= data_t'(shifted);
                hold_ovf  <= spill;
            end
        end
    end

    assign res.data     = LANE_BITS'(hold_data);
    assign res.overflow = hold_ovf;

endmodule

//--- verilog/spu_operand_fanout.sv
module spu_operand_fanout #(
    parameter int LANES      = spu_cfg_pkg::LANES,
    parameter int LANE_BITS  = spu_cfg_pkg::LANE_BITS,
    parameter int SHIFT_BITS = spu_cfg_pkg::SHIFT_BITS
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cke,

    input  logic [LANES*LANE_BITS-1:0]    s_data,         // lane 0 in low bits
    input  logic [LANES*SHIFT_BITS-1:0]   s_shift_vec,    // per-lane amounts
    input  logic [SHIFT_BITS-1:0]         s_shift_bcast,  // shared amount
    input  logic                          s_bcast,        // use shared amount
    input  logic [LANES-1:0]              s_lane_en,      // lane mask
    input  logic                          s_valid,
    input  logic                          s_clear,

    output spu_op_pkg::lane_cmd_t [LANES-1:0] cmd
);

    import spu_op_pkg::*;

    lane_cmd_t [LANES-1:0] cmd_next;

    // --------------------
    // per-lane split
    // --------------------

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // masked lanes see neither strobe
            cmd_next[i].clear = s_clear & s_lane_en[i];
            cmd_next[i].valid = s_valid & s_lane_en[i];

            if (s_bcast) begin
                cmd_next[i].shift = s_shift_bcast;  // broadcast mode
            end else begin
                cmd_next[i].shift = s_shift_vec[i*SHIFT_BITS +: SHIFT_BITS];
            end

            cmd_next[i].data = s_data[i*LANE_BITS +: LANE_BITS];
        end
    end

    // --------------------
    // command register
    // --------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd <= {LANES{LANE_CMD_IDLE}};  // strobes inactive
        end else if (cke) begin
            cmd <= cmd_next;
        end
    end

endmodule

//--- verilog/spu_op_pkg.sv
package spu_op_pkg;

    import spu_cfg_pkg::*;

    // --------------------
    // lane command
    // --------------------

    typedef struct packed {
        logic                  clear;   // load clear value even with valid
        logic                  valid;   // load shifted data
        logic [SHIFT_BITS-1:0] shift;   // left shift amount
        logic [LANE_BITS-1:0]  data;    // operand
    } lane_cmd_t;

    // idle command with both strobes low
    localparam lane_cmd_t LANE_CMD_IDLE = '{
        clear: 1'b0,
        valid: 1'b0,
        shift: '0,
        data:  '0
    };

    // --------------------
    // lane result
    // --------------------

    typedef struct packed {
        logic [LANE_BITS-1:0] data;      // held lane value
        logic                 overflow;  // ones shifted out of the lane
    } lane_res_t;

endpackage

//--- verilog/spu_cfg_pkg.sv
package spu_cfg_pkg;

    // --------------------
    // lane geometry
    // --------------------

    // default number of lanes in one vector word
    localparam int LANES = 4;

    // width of one lane
    localparam int LANE_BITS = 8;

    // one extra bit over log2 so a full-width shift can be coded
    localparam int SHIFT_BITS = $clog2(LANE_BITS) + 1;

    // --------------------
    // reset and clear
    // --------------------

    // all-ones lane value after clear or reset
    localparam logic [LANE_BITS-1:0] CLEAR_VALUE = '1;

endpackage
